// File: all.f
+incdir+include
hdl/alpha_pkg.sv
hdl/startup_sequencer.sv
hdl/alpha_readout.sv
hdl/word_fifo.sv
hdl/packet_summer.sv
hdl/alpha_readout_top.sv
test/tb_alpha_readout_top.sv

// File: Makefile
# Verilator simulation of the readout subsystem
# any variable below can be overridden, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_alpha_readout_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= all tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST) | grep -v '^+')
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) && echo "simulation passed" \
		|| (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: include/alpha_tb_vectors.svh
`ifndef ALPHA_TB_VECTORS_SVH
`define ALPHA_TB_VECTORS_SVH

// ---------------------------------------------------------------------------
// stimulus table
// ---------------------------------------------------------------------------

// row kinds
localparam logic [1:0] row_packet = 2'd0;
localparam logic [1:0] row_noise = 2'd1;
localparam logic [1:0] row_button = 2'd2;

// columns: kind, four words, expected modulo 2^16 sum, noise length in bits
typedef struct packed {
	logic [1:0]  kind;
	logic [15:0] w0;
	logic [15:0] w1;
	logic [15:0] w2;
	logic [15:0] w3;
	logic [15:0] sum;
	logic [7:0]  noise_bits;
} vec_t;

localparam int num_rows = 9;

// early button, two packets before arming, noise, arming button,
// three back-to-back packets, closing noise
localparam vec_t table_rows [num_rows] = '{
	'{row_button, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 8'd0},
	'{row_packet, 16'h1234, 16'h5678, 16'h9abc, 16'hdef0, 16'he258, 8'd0},
	'{row_packet, 16'hffff, 16'h0001, 16'h8000, 16'h8000, 16'h0000, 8'd0},
	'{row_noise,  16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 8'd40},
	'{row_button, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 8'd0},
	'{row_packet, 16'h0000, 16'h0000, 16'h0000, 16'h0001, 16'h0001, 8'd0},
	'{row_packet, 16'haaaa, 16'h5555, 16'h0f0f, 16'hf0f0, 16'hfffe, 8'd0},
	'{row_packet, 16'h0102, 16'h0304, 16'h0506, 16'h0708, 16'h1014, 8'd0},
	'{row_noise,  16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 8'd40}
};

`endif

// File: test/tb_alpha_readout_top.sv
`default_nettype none
`timescale 1ns/1ps

module tb_alpha_readout_top import alpha_pkg::*; ();
	localparam int stage1_cycles = 64;
	localparam int stage2_cycles = 32;

	`include "alpha_tb_vectors.svh"

	logic sysclk;
	logic reset;
	logic data_a;
	logic button;
	logic header;
	logic msn;
	logic stage_1_done;
	logic stage_2_done;
	logic stage_3_done;
	logic packet_done;
	logic [15:0] packet_sum;
	logic [7:0] packet_count;
	logic overflow;

	int errors = 0;
	int checks = 0;
	int checked = 0;
	int header_count = 0;
	int msn_count = 0;
	int stage1_at = -1;
	int stage2_at = -1;
	bit overflow_seen = 0;
	logic [15:0] expected_q[$];
	logic [15:0] seen_q[$];

	alpha_readout_top #(
		.stage1_cycles(stage1_cycles),
		.stage2_cycles(stage2_cycles)
	) u_dut (
		.sysclk(sysclk),
		.reset(reset),
		.data_a(data_a),
		.button(button),
		.header(header),
		.msn(msn),
		.stage_1_done(stage_1_done),
		.stage_2_done(stage_2_done),
		.stage_3_done(stage_3_done),
		.packet_done(packet_done),
		.packet_sum(packet_sum),
		.packet_count(packet_count),
		.overflow(overflow)
	);

	initial begin
		sysclk = 1'b0;
		forever #5 sysclk = ~sysclk;
	end

	// ---------------------------------------------------------------------------
	// reference model and helpers
	// ---------------------------------------------------------------------------
	function automatic logic [15:0] word_total(input vec_t r);
		logic [15:0] total;
		total = r.w0 + r.w1;
		total = total + r.w2;
		total = total + r.w3;
		return total;
	endfunction

	function automatic int row_bits(input vec_t r);
		if (r.kind == row_packet) begin
			return header_width + 4 * word_width;
		end else if (r.kind == row_noise) begin
			return r.noise_bits;
		end
		return 4;
	endfunction

	task automatic compare_value(input logic [15:0] actual, input logic [15:0] expected,
		input string what);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic check_flag(input bit cond, input string what);
		checks++;
		assert (cond) else begin
			errors++;
			$display("Error at %0t ns: %s", $time, what);
		end
	endtask

	task automatic shift_bits(input logic [15:0] value, input int width);
		for (int i = width - 1; i >= 0; i--) begin
			@(posedge sysclk);
			#1 data_a = value[i];
		end
	endtask

	task automatic send_packet(input vec_t r);
		shift_bits(16'(header_pattern), header_width);
		shift_bits(r.w0, word_width);
		shift_bits(r.w1, word_width);
		shift_bits(r.w2, word_width);
		shift_bits(r.w3, word_width);
	endtask

	// every random bit goes out twice, so no run of alternating bits can form
	task automatic send_noise(input int bits);
		logic [31:0] r;
		for (int i = 0; i < bits / 2; i++) begin
			r = $urandom();
			shift_bits({2{r[0]}}, 2);
		end
	endtask

	task automatic press_button();
		@(posedge sysclk);
		#1 data_a = 1'b0;
		button = 1'b1;
		@(posedge sysclk);
		#1 button = 1'b0;
		repeat (2) @(posedge sysclk);
		#1;
	endtask

	task automatic wait_for_sums(input int n);
		while (seen_q.size() < n) begin
			@(posedge sysclk);
			#3;
		end
	endtask

	task automatic check_sums();
		while (checked < seen_q.size()) begin
			if (checked < expected_q.size()) begin
				compare_value(seen_q[checked], expected_q[checked],
					$sformatf("packet %0d sum", checked));
			end else begin
				check_flag(1'b0, "packet_done pulsed more often than packets were sent");
			end
			checked++;
		end
	endtask

	// ---------------------------------------------------------------------------
	// monitors and run limit
	// ---------------------------------------------------------------------------
	initial begin
		forever begin
			@(posedge sysclk);
			#2;
			if (!reset) begin
				if (packet_done) seen_q.push_back(packet_sum);
				if (header) header_count++;
				if (msn) msn_count++;
				if (overflow) overflow_seen = 1'b1;
			end
		end
	end

	// edge numbers of the stage done levels, counted from reset release
	initial begin
		int n;
		n = 0;
		@(negedge reset);
		while (!stage_2_done) begin
			@(posedge sysclk);
			n++;
			#2;
			if (stage_1_done && stage1_at < 0) stage1_at = n;
			if (stage_2_done) stage2_at = n;
		end
	end

	initial begin
		int cycles;
		int limit;
		cycles = 0;
		limit = stage1_cycles + stage2_cycles + 8 + 200;
		for (int i = 0; i < num_rows; i++) begin
			limit += row_bits(table_rows[i]);
		end
		while (cycles <= limit) begin
			@(posedge sysclk);
			cycles++;
		end
		$display("timeout after %0d cycles, the DUT never finished", cycles);
		$display("tests failed");
		$finish;
	end

	// ---------------------------------------------------------------------------
	// main sequence
	// ---------------------------------------------------------------------------
	initial begin
		int before_err;
		int before_hdr;
		int before_msn;
		logic expect_arm;
		vec_t r;

		void'($urandom(8));
		reset = 1'b1;
		data_a = 1'b0;
		button = 1'b0;
		repeat (8) @(posedge sysclk);
		#1 reset = 1'b0;
		#1;

		check_flag(!stage_1_done && !stage_2_done && !stage_3_done, "done level high after reset");
		check_flag(!packet_done && !overflow, "packet_done or overflow high after reset");
		$display("reset state: %s", errors == 0 ? "ok" : "fail");

		for (int i = 0; i < num_rows; i++) begin
			r = table_rows[i];
			before_err = errors;
			before_hdr = header_count;
			before_msn = msn_count;
			case (r.kind)
				row_packet: begin
					compare_value(r.sum, word_total(r), $sformatf("table row %0d sum", i));
					expected_q.push_back(word_total(r));
					send_packet(r);
					compare_value(16'(header_count), 16'(before_hdr + 1), "header pulses");
					// first nybble of each of the four words
					compare_value(16'(msn_count - before_msn), 16'(4 * nybble_width),
						"msn cycles");
					if (!stage_3_done) begin
						check_flag(seen_q.size() == 0, "packet_done before arming");
					end
					$display("row %0d packet: %s", i, errors == before_err ? "ok" : "fail");
				end
				row_noise: begin
					send_noise(r.noise_bits);
					compare_value(16'(header_count), 16'(before_hdr), "header pulses in noise");
					compare_value(16'(msn_count - before_msn), 16'd0, "msn cycles in noise");
					$display("row %0d noise: %s", i, errors == before_err ? "ok" : "fail");
				end
				default: begin
					expect_arm = stage_2_done;
					if (expect_arm) begin
						check_flag(seen_q.size() == 0, "packet_done before arming");
					end
					press_button();
					compare_value(16'(stage_3_done), 16'(expect_arm), "stage_3_done");
					if (expect_arm) begin
						// held packets drain once armed
						wait_for_sums(expected_q.size());
						check_sums();
						compare_value(16'(packet_count), 16'(expected_q.size()), "packet_count");
					end
					$display("row %0d button: %s", i, errors == before_err ? "ok" : "fail");
				end
			endcase
		end

		data_a = 1'b0;
		before_err = errors;
		wait_for_sums(expected_q.size());
		check_sums();
		compare_value(16'(packet_count), 16'(expected_q.size()), "final packet_count");
		check_flag(!overflow_seen, "FIFO overflow flag rose during the run");
		compare_value(16'(stage1_at), 16'(stage1_cycles), "stage_1_done cycle");
		compare_value(16'(stage2_at - stage1_at), 16'(stage2_cycles), "stage_2_done delay");
		$display("final checks: %s", errors == before_err ? "ok" : "fail");

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: hdl/alpha_readout_top.sv
`default_nettype none
`timescale 1ns/1ps

module alpha_readout_top import alpha_pkg::*; #(
	parameter int stage1_cycles = 64,
	parameter int stage2_cycles = 32,
	parameter int words_per_packet = 4,
	parameter int fifo_depth = 8
) (
	input  logic                  sysclk,
	input  logic                  reset,
	input  logic                  data_a,
	input  logic                  button,
	output logic                  header,
	output logic                  msn,
	output logic                  stage_1_done,
	output logic                  stage_2_done,
	output logic                  stage_3_done,
	output logic                  packet_done,
	output logic [word_width-1:0] packet_sum,
	output logic [7:0]            packet_count,
	output logic                  overflow
);
	logic push;
	readout_word_t push_data;
	logic pop;
	readout_word_t pop_data;
	logic empty;

	startup_sequencer #(
		.stage1_cycles(stage1_cycles),
		.stage2_cycles(stage2_cycles)
	) sequencer (
		.sysclk(sysclk),
		.reset(reset),
		.button(button),
		.stage_1(),
		.stage_2(),
		.stage_3(),
		.stage_1_done(stage_1_done),
		.stage_2_done(stage_2_done),
		.stage_3_done(stage_3_done)
	);

	// producer, one bit per sysclk off data_a
	alpha_readout #(
		.words_per_packet(words_per_packet)
	) readout (
		.sysclk(sysclk),
		.reset(reset),
		.data_a(data_a),
		.header(header),
		.msn(msn),
		.nybble(),
		.nybble_counter(),
		.push(push),
		.push_data(push_data)
	);

	word_fifo #(
		.payload_t(readout_word_t),
		.fifo_depth(fifo_depth)
	) fifo (
		.sysclk(sysclk),
		.reset(reset),
		.push(push),
		.push_data(push_data),
		.pop(pop),
		.pop_data(pop_data),
		.empty(empty),
		.full(),
		.overflow(overflow)
	);

	// consumer is held off until stage 3
	packet_summer summer (
		.sysclk(sysclk),
		.reset(reset),
		.armed(stage_3_done),
		.empty(empty),
		.pop(pop),
		.pop_data(pop_data),
		.packet_done(packet_done),
		.packet_sum(packet_sum),
		.packet_count(packet_count)
	);

endmodule

`default_nettype wire

// File: hdl/packet_summer.sv
`default_nettype none
`timescale 1ns/1ps

module packet_summer import alpha_pkg::*; (
	input  logic                  sysclk,
	input  logic                  reset,
	input  logic                  armed,
	input  logic                  empty,
	output logic                  pop,
	input  readout_word_t         pop_data,
	output logic                  packet_done,
	output logic [word_width-1:0] packet_sum,
	output logic [7:0]            packet_count
);
	// words of one packet arrive a word time apart, so a longer silence
	// with the fifo empty ends the packet being held
	localparam int idle_limit = word_width + nybble_width;
	localparam int idle_width = $clog2(idle_limit + 1);

	logic data_valid;
	logic held;
	logic [word_width-1:0] sum;
	logic [idle_width-1:0] idle_count;
	logic close_first;
	logic close_idle;

	assign pop = armed && !empty;

	// next packet's first word closes the previous packet
	assign close_first = data_valid && pop_data.first && held;
	assign close_idle = held && !data_valid && empty
		&& (idle_count == idle_width'(idle_limit - 1));

	// ---------------------------------------------------------------------------
	// control
	// ---------------------------------------------------------------------------
	always_ff @(posedge sysclk) begin
		if (reset) begin
			data_valid <= 1'b0;
			held <= 1'b0;
			idle_count <= '0;
			packet_done <= 1'b0;
			packet_count <= '0;
		end else begin
			data_valid <= pop;
			packet_done <= close_first || close_idle;
			if (close_first || close_idle) begin
				packet_count <= packet_count + 8'd1;
			end
			if (data_valid) begin
				held <= 1'b1;
				idle_count <= '0;
			end else if (close_idle) begin
				held <= 1'b0;
				idle_count <= '0;
			end else if (held && empty) begin
				idle_count <= idle_count + 1'b1;
			end
		end
	end

	// ---------------------------------------------------------------------------
	// running sum, modulo 2^16
	// ---------------------------------------------------------------------------
	always_ff @(posedge sysclk) begin
		if (close_first || close_idle) begin
			packet_sum <= sum;
		end
		if (data_valid) begin
			if (pop_data.first || !held) begin
				sum <= pop_data.data;
			end else begin
				sum <= sum + pop_data.data;
			end
		end
	end

	// a packet can only end after some word was taken in
	assert property (@(posedge sysclk) disable iff (reset) packet_done |-> $past(held))
		else $error("packet_done without a popped word");

endmodule

`default_nettype wire

// File: hdl/word_fifo.sv
`default_nettype none
`timescale 1ns/1ps

module word_fifo #(
	parameter type payload_t = logic [15:0],
	parameter int fifo_depth = 8
) (
	input  logic     sysclk,
	input  logic     reset,
	input  logic     push,
	input  payload_t push_data,
	input  logic     pop,
	output payload_t pop_data,
	output logic     empty,
	output logic     full,
	output logic     overflow
);
	localparam int addr_width = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;

	if (fifo_depth != (1 << addr_width)) begin : g_depth_check
		$error("word_fifo depth must be a power of two");
	end

	payload_t mem [fifo_depth];

	// top bit of each pointer tells a full buffer from an empty one
	logic [addr_width:0] wr_ptr;
	logic [addr_width:0] rd_ptr;
	logic do_push;
	logic do_pop;

	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[addr_width] != rd_ptr[addr_width])
		&& (wr_ptr[addr_width-1:0] == rd_ptr[addr_width-1:0]);

	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	// ---------------------------------------------------------------------------
	// pointers and overflow
	// ---------------------------------------------------------------------------
	always_ff @(posedge sysclk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			overflow <= 1'b0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// word is lost, flag stays up until reset
			if (push && full) begin
				overflow <= 1'b1;
			end
		end
	end

	// ---------------------------------------------------------------------------
	// storage
	// ---------------------------------------------------------------------------
	always_ff @(posedge sysclk) begin
		if (do_push) begin
			mem[wr_ptr[addr_width-1:0]] <= push_data;
		end
		if (do_pop) begin
			pop_data <= mem[rd_ptr[addr_width-1:0]];
		end
	end

	// consumer only reads when there is something to read
	assert property (@(posedge sysclk) disable iff (reset) pop |-> !empty)
		else $error("pop while fifo empty");

endmodule

`default_nettype wire

// File: hdl/alpha_readout.sv
`default_nettype none
`timescale 1ns/1ps

module alpha_readout import alpha_pkg::*; #(
	parameter int words_per_packet = 4
) (
	input  logic                    sysclk,
	input  logic                    reset,
	input  logic                    data_a,
	output logic                    header,
	output logic                    msn,
	output logic [nybble_width-1:0] nybble,
	output logic [1:0]              nybble_counter,
	output logic                    push,
	output readout_word_t           push_data
);
	localparam int word_count_width = (words_per_packet > 1) ? $clog2(words_per_packet) : 1;
	localparam logic [word_count_width-1:0] last_word =
		word_count_width'(words_per_packet - 1);
	localparam logic [3:0] last_bit = 4'(word_width - 1);

	typedef enum logic [1:0] {
		st_hunt,
		st_word,
		st_done
	} state_t;

	state_t state;
	// header search window
	logic [header_width-1:0] window;
	// the most recent bits off the line, oldest at the top
	logic [word_width-2:0] history;
	logic [3:0] bit_count;
	logic [word_count_width-1:0] word_count;
	logic header_hit;
	logic word_end;

	assign header_hit = (state == st_hunt) && (window == header_pattern);
	assign word_end = (state == st_word) && (bit_count == last_bit);

	// bit 0 of word 0 is on the line while the header match is seen
	assign msn = (header_hit || state == st_word) && (bit_count[3:2] == 2'd0);
	assign nybble_counter = bit_count[3:2];

	// ---------------------------------------------------------------------------
	// control
	// ---------------------------------------------------------------------------
	always_ff @(posedge sysclk) begin
		if (reset) begin
			state <= st_hunt;
			window <= '0;
			bit_count <= '0;
			word_count <= '0;
			header <= 1'b0;
			push <= 1'b0;
		end else begin
			header <= header_hit;
			push <= word_end;
			window <= {window[header_width-2:0], data_a};
			case (state)
				st_hunt: begin
					if (header_hit) begin
						// this edge samples the first data bit
						state <= st_word;
						bit_count <= 4'd1;
						word_count <= '0;
					end
				end
				st_word: begin
					// wraps to zero after the last bit of a word
					bit_count <= bit_count + 4'd1;
					if (word_end) begin
						word_count <= word_count + 1'b1;
						if (word_count == last_word) begin
							state <= st_done;
							// forget the data bits before hunting again
							window <= '0;
						end
					end
				end
				st_done: begin
					// last push of the packet goes out here
					state <= st_hunt;
					word_count <= '0;
				end
				default: begin
					state <= st_hunt;
				end
			endcase
		end
	end

	// ---------------------------------------------------------------------------
	// data path
	// ---------------------------------------------------------------------------
	always_ff @(posedge sysclk) begin
		history <= {history[word_width-3:0], data_a};
		if (state == st_word && bit_count[1:0] == 2'b11) begin
			nybble <= {history[nybble_width-2:0], data_a};
		end
		if (word_end) begin
			push_data.data <= {history, data_a};
			push_data.first <= (word_count == '0);
		end
	end

	// a header never lands on a word push
	assert property (@(posedge sysclk) disable iff (reset) !(header && push))
		else $error("header and push in the same cycle");

endmodule

`default_nettype wire

// File: hdl/startup_sequencer.sv
`default_nettype none
`timescale 1ns/1ps

module startup_sequencer #(
	parameter int stage1_cycles = 64,
	parameter int stage2_cycles = 32
) (
	input  logic sysclk,
	input  logic reset,
	input  logic button,
	output logic stage_1,
	output logic stage_2,
	output logic stage_3,
	output logic stage_1_done,
	output logic stage_2_done,
	output logic stage_3_done
);
	localparam int stage1_width = (stage1_cycles > 1) ? $clog2(stage1_cycles) : 1;
	localparam int stage2_width = (stage2_cycles > 1) ? $clog2(stage2_cycles) : 1;

	logic [stage1_width-1:0] stage1_count;
	logic [stage2_width-1:0] stage2_count;

	// ---------------------------------------------------------------------------
	// stage 1, timed from the end of reset
	// ---------------------------------------------------------------------------
	always_ff @(posedge sysclk) begin
		if (reset) begin
			stage1_count <= stage1_width'(stage1_cycles - 1);
			stage_1 <= 1'b0;
			stage_1_done <= 1'b0;
		end else begin
			stage_1 <= 1'b0;
			if (!stage_1_done) begin
				if (stage1_count == '0) begin
					stage_1 <= 1'b1;
					stage_1_done <= 1'b1;
				end else begin
					stage1_count <= stage1_count - 1'b1;
				end
			end
		end
	end

	// stage 2 starts counting once stage 1 has occurred
	always_ff @(posedge sysclk) begin
		if (reset) begin
			stage2_count <= stage2_width'(stage2_cycles - 1);
			stage_2 <= 1'b0;
			stage_2_done <= 1'b0;
		end else begin
			stage_2 <= 1'b0;
			if (stage_1_done && !stage_2_done) begin
				if (stage2_count == '0) begin
					stage_2 <= 1'b1;
					stage_2_done <= 1'b1;
				end else begin
					stage2_count <= stage2_count - 1'b1;
				end
			end
		end
	end

	// ---------------------------------------------------------------------------
	// stage 3, operator button once stage 2 is done
	// ---------------------------------------------------------------------------
	always_ff @(posedge sysclk) begin
		if (reset) begin
			stage_3 <= 1'b0;
			stage_3_done <= 1'b0;
		end else begin
			stage_3 <= 1'b0;
			// early presses fall through here
			if (button && stage_2_done && !stage_3_done) begin
				stage_3 <= 1'b1;
				stage_3_done <= 1'b1;
			end
		end
	end

	// stages complete strictly in order
	assert property (@(posedge sysclk) disable iff (reset)
		$rose(stage_2_done) |-> $past(stage_1_done))
		else $error("stage 2 done before stage 1");
	assert property (@(posedge sysclk) disable iff (reset)
		$rose(stage_3_done) |-> $past(stage_2_done))
		else $error("stage 3 done before stage 2");

endmodule

`default_nettype wire

// File: hdl/alpha_pkg.sv
`default_nettype none

package alpha_pkg;

	// ---------------------------------------------------------------------------
	// serial readout format
	// ---------------------------------------------------------------------------

	// bits per data word and per nybble on the serial line
	localparam int word_width = 16;
	localparam int nybble_width = 4;

	// packet start marker
	localparam int header_width = 8;
	// alternating bits, so an idle-low line never looks like a header
	localparam logic [header_width-1:0] header_pattern = 8'b1010_1010;

	// ---------------------------------------------------------------------------
	// buffer entry
	// ---------------------------------------------------------------------------

	// first marks word 0 of a packet
	typedef struct packed {
		logic [word_width-1:0] data;
		logic                  first;
	} readout_word_t;

endpackage

`default_nettype wire
